// File: design/mips_pkg.sv
package mips_pkg;

    ////////////////////////////////////////////////////////////
    // decoded operations
    ////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        OP_ADDU,
        OP_ADDIU,
        OP_SUBU,
        OP_AND,
        OP_ANDI,
        OP_OR,
        OP_ORI,
        OP_XOR,
        OP_XORI,
        OP_SLT,
        OP_SLTI,
        OP_SLTU,
        OP_SLTIU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_LW,
        OP_LB,
        OP_LBU,
        OP_SW,
        OP_SB,
        OP_BEQ,
        OP_BNE,
        OP_J,
        OP_JAL,
        OP_JR,
        OP_INVALID              // unknown encoding, executes as a no-op
    } op_t;

    ////////////////////////////////////////////////////////////
    // sequencer states
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ST_FETCH  = 2'd0,
        ST_EXEC1  = 2'd1,
        ST_EXEC2  = 2'd2,
        ST_HALTED = 2'd3
    } seq_state_t;

    ////////////////////////////////////////////////////////////
    // fixed addresses and register numbers
    ////////////////////////////////////////////////////////////

    localparam logic [31:0] reset_vector = 32'hbfc0_0000;   // first fetch after reset
    localparam logic [31:0] halt_address = 32'h0000_0000;   // jr here stops the core
    localparam logic [4:0]  reg_v0       = 5'd2;            // result register shown on the port

endpackage

// File: design/mips_sequencer.sv
`timescale 1ns/1ps

module mips_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic mem_stall,
    input  logic needs_mem,
    input  logic pc_halt,
    output logic fetch,
    output logic exec1,
    output logic exec2,
    output logic active
);
    import mips_pkg::*;

    seq_state_t state;
    logic       started;    // low until the first clock after reset is released

    assign fetch  = (state == ST_FETCH) & started;
    assign exec1  = (state == ST_EXEC1);
    assign exec2  = (state == ST_EXEC2);
    assign active = (state != ST_HALTED);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_FETCH;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            case (state)
                ST_FETCH: if (fetch && !mem_stall) state <= ST_EXEC1;  // word fetched
                ST_EXEC1: begin
                    if (needs_mem)    state <= ST_EXEC2;
                    else if (pc_halt) state <= ST_HALTED;
                    else              state <= ST_FETCH;
                end
                ST_EXEC2: if (!mem_stall) state <= ST_FETCH;           // data access done
                default:  state <= ST_HALTED;                         // stays until reset
            endcase
        end
    end

endmodule

// File: design/mips_decode.sv
`timescale 1ns/1ps

module mips_decode (
    input  logic           clk,
    input  logic           rst,
    input  logic           fetch,
    input  logic           mem_stall,
    input  logic [31:0]    readdata,
    output mips_pkg::op_t  op,
    output logic [4:0]     rs,
    output logic [4:0]     rt,
    output logic [4:0]     dest,
    output logic [4:0]     shamt,
    output logic [31:0]    imm,
    output logic [25:0]    jump_index,
    output logic           reg_write,
    output logic           needs_mem
);
    import mips_pkg::*;

    logic [31:0] instr;
    logic [5:0]  opcode, funct;

    // instruction register, loaded when the fetch read completes
    always_ff @(posedge clk) begin
        if (rst) instr <= 32'h0;
        else if (fetch && !mem_stall) instr <= readdata;
    end

    assign opcode     = instr[31:26];
    assign funct      = instr[5:0];
    assign rs         = instr[25:21];
    assign rt         = instr[20:16];
    assign shamt      = instr[10:6];
    assign jump_index = instr[25:0];

    always_comb begin
        op = OP_INVALID;
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h00: op = OP_SLL;
                    6'h02: op = OP_SRL;
                    6'h03: op = OP_SRA;
                    6'h08: op = OP_JR;
                    6'h21: op = OP_ADDU;
                    6'h23: op = OP_SUBU;
                    6'h24: op = OP_AND;
                    6'h25: op = OP_OR;
                    6'h26: op = OP_XOR;
                    6'h2a: op = OP_SLT;
                    6'h2b: op = OP_SLTU;
                    default: op = OP_INVALID;
                endcase
            end
            6'h02: op = OP_J;
            6'h03: op = OP_JAL;
            6'h04: op = OP_BEQ;
            6'h05: op = OP_BNE;
            6'h09: op = OP_ADDIU;
            6'h0a: op = OP_SLTI;
            6'h0b: op = OP_SLTIU;
            6'h0c: op = OP_ANDI;
            6'h0d: op = OP_ORI;
            6'h0e: op = OP_XORI;
            6'h0f: op = OP_LUI;
            6'h20: op = OP_LB;
            6'h23: op = OP_LW;
            6'h24: op = OP_LBU;
            6'h28: op = OP_SB;
            6'h2b: op = OP_SW;
            default: op = OP_INVALID;
        endcase
    end

    // logical immediates are zero extended, all others sign extended
    assign imm = (op inside {OP_ANDI, OP_ORI, OP_XORI}) ? {16'h0, instr[15:0]}
                                                         : {{16{instr[15]}}, instr[15:0]};

    assign dest = (op == OP_JAL) ? 5'd31 : (opcode == 6'h00) ? instr[15:11] : rt;

    assign reg_write = op inside {OP_ADDU, OP_ADDIU, OP_SUBU, OP_AND, OP_ANDI, OP_OR, OP_ORI,
                                  OP_XOR, OP_XORI, OP_SLT, OP_SLTI, OP_SLTU, OP_SLTIU, OP_SLL,
                                  OP_SRL, OP_SRA, OP_LUI, OP_LW, OP_LB, OP_LBU, OP_JAL};
    assign needs_mem = op inside {OP_LW, OP_LB, OP_LBU, OP_SW, OP_SB};

endmodule

// File: design/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::op_t op,
    input  logic [31:0]   a,
    input  logic [31:0]   b,
    input  logic [31:0]   imm,
    input  logic [4:0]    shamt,
    output logic [31:0]   result,
    output logic          equal
);
    import mips_pkg::*;

    logic [31:0] operand_b;

    // register operand for r-type and branches, immediate for the rest
    always_comb begin
        case (op)
            OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR,
            OP_SLT, OP_SLTU, OP_BEQ, OP_BNE:    operand_b = b;
            default:                            operand_b = imm;
        endcase
    end

    assign equal = (a == b);    // branch compare is always rs against rt

    always_comb begin
        case (op)
            OP_SUBU:           result = a - operand_b;
            OP_AND, OP_ANDI:   result = a & operand_b;
            OP_OR, OP_ORI:     result = a | operand_b;
            OP_XOR, OP_XORI:   result = a ^ operand_b;
            OP_SLT, OP_SLTI:   result = {31'h0, $signed(a) < $signed(operand_b)};
            OP_SLTU, OP_SLTIU: result = {31'h0, a < operand_b};
            OP_SLL:            result = b << shamt;
            OP_SRL:            result = b >> shamt;
            OP_SRA:            result = $unsigned($signed(b) >>> shamt);
            OP_LUI:            result = {operand_b[15:0], 16'h0};
            OP_INVALID:        result = 32'h0;
            default:           result = a + operand_b;  // addu, addiu and effective address
        endcase
    end

endmodule

// File: design/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic        write_enable,
    input  logic [4:0]  read_a_index,
    input  logic [4:0]  read_b_index,
    input  logic [4:0]  write_index,
    input  logic [31:0] write_data,
    output logic [31:0] read_a_data,
    output logic [31:0] read_b_data,
    output logic [31:0] v0
);
    import mips_pkg::*;

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) regs[i] <= 32'h0;
        end else if (write_enable && write_index != 5'd0) begin
            regs[write_index] <= write_data;    // $zero never changes
        end
    end

    assign read_a_data = regs[read_a_index];
    assign read_b_data = regs[read_b_index];
    assign v0          = regs[reg_v0];

endmodule

// File: design/mips_pc.sv
`timescale 1ns/1ps

module mips_pc (
    input  logic          clk,
    input  logic          rst,
    input  logic          exec1,
    input  mips_pkg::op_t op,
    input  logic [31:0]   imm,
    input  logic [25:0]   jump_index,
    input  logic [31:0]   rs_data,
    input  logic          equal,
    output logic [31:0]   pc,
    output logic [31:0]   pc_link,
    output logic          pc_halt
);
    import mips_pkg::*;

    logic [31:0] next_pc;       // address of the delay slot
    logic [31:0] branch_target, successor;

    assign branch_target = next_pc + {imm[29:0], 2'b00};
    assign pc_link       = pc + 32'd8;
    assign pc_halt       = (op == OP_JR) && (rs_data == halt_address);

    // what follows the delay slot
    always_comb begin
        successor = next_pc + 32'd4;
        case (op)
            OP_BEQ:        if (equal)  successor = branch_target;
            OP_BNE:        if (!equal) successor = branch_target;
            OP_J, OP_JAL:  successor = {next_pc[31:28], jump_index, 2'b00};
            OP_JR:         successor = rs_data;
            default:       successor = next_pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= reset_vector;
            next_pc <= reset_vector + 32'd4;
        end else if (exec1) begin
            pc      <= next_pc;
            next_pc <= successor;
        end
    end

endmodule

// File: design/mips_mem_unit.sv
`timescale 1ns/1ps

module mips_mem_unit (
    input  logic          fetch,
    input  logic          exec2,
    input  mips_pkg::op_t op,
    input  logic [31:0]   pc,
    input  logic [31:0]   alu_result,
    input  logic [31:0]   store_data,
    input  logic [31:0]   readdata,
    input  logic          waitrequest,
    output logic [31:0]   address,
    output logic          read,
    output logic          write,
    output logic [31:0]   writedata,
    output logic [3:0]    byteenable,
    output logic [31:0]   load_data,
    output logic          mem_stall
);
    import mips_pkg::*;

    logic       is_load, is_store, is_byte;
    logic [7:0] lane;

    assign is_load  = op inside {OP_LW, OP_LB, OP_LBU};
    assign is_store = op inside {OP_SW, OP_SB};
    assign is_byte  = op inside {OP_LB, OP_LBU, OP_SB};

    ////////////////////////////////////////////////////////////
    // bus request
    ////////////////////////////////////////////////////////////

    always_comb begin
        address    = pc;
        read       = 1'b0;
        write      = 1'b0;
        byteenable = 4'hf;
        writedata  = store_data;
        if (fetch) begin
            read = 1'b1;                                        // instruction word
        end else if (exec2) begin
            address = {alu_result[31:2], 2'b00};
            read    = is_load;
            write   = is_store;
            if (is_byte) byteenable = 4'b0001 << alu_result[1:0];  // little-endian lanes
            if (op == OP_SB) writedata = {4{store_data[7:0]}};
        end
    end

    assign mem_stall = waitrequest & (read | write);

    ////////////////////////////////////////////////////////////
    // load data
    ////////////////////////////////////////////////////////////

    assign lane = readdata[8*alu_result[1:0] +: 8];

    always_comb begin
        case (op)
            OP_LB:   load_data = {{24{lane[7]}}, lane};
            OP_LBU:  load_data = {24'h0, lane};
            default: load_data = readdata;
        endcase
    end

endmodule

// File: design/mips_cpu_bus.sv
`timescale 1ns/1ps

module mips_cpu_bus (
    input  logic        clk,
    input  logic        rst,
    output logic        active,
    output logic [31:0] register_v0,

    // avalon-mm master
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    input  logic        waitrequest,
    output logic [31:0] writedata,
    output logic [3:0]  byteenable,
    input  logic [31:0] readdata
);
    import mips_pkg::*;

    logic        fetch, exec1, exec2;
    logic        mem_stall, needs_mem, reg_write, pc_halt, equal, reg_write_en;
    op_t         op;
    logic [4:0]  rs, rt, dest, shamt;
    logic [31:0] imm, rs_data, rt_data, alu_result, load_data, pc, pc_link, reg_write_data;
    logic [25:0] jump_index;

    ////////////////////////////////////////////////////////////
    // register write path
    ////////////////////////////////////////////////////////////

    // write happens in the last execution cycle of the instruction
    assign reg_write_en = reg_write & ((exec1 & ~needs_mem) | (exec2 & ~mem_stall));

    always_comb begin
        case (op)
            OP_LW, OP_LB, OP_LBU: reg_write_data = load_data;
            OP_JAL:               reg_write_data = pc_link;   // return past the delay slot
            default:              reg_write_data = alu_result;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////

    mips_sequencer i_mips_sequencer (
        .clk(clk), .rst(rst), .mem_stall(mem_stall), .needs_mem(needs_mem), .pc_halt(pc_halt),
        .fetch(fetch), .exec1(exec1), .exec2(exec2), .active(active)
    );

    mips_decode i_mips_decode (
        .clk(clk), .rst(rst), .fetch(fetch), .mem_stall(mem_stall), .readdata(readdata),
        .op(op), .rs(rs), .rt(rt), .dest(dest), .shamt(shamt), .imm(imm),
        .jump_index(jump_index), .reg_write(reg_write), .needs_mem(needs_mem)
    );

    mips_alu i_mips_alu (
        .op(op), .a(rs_data), .b(rt_data), .imm(imm), .shamt(shamt),
        .result(alu_result), .equal(equal)
    );

    // dest already names $31 for jal
    mips_regfile i_mips_regfile (
        .clk(clk), .rst(rst), .write_enable(reg_write_en), .read_a_index(rs),
        .read_b_index(rt), .write_index(dest), .write_data(reg_write_data),
        .read_a_data(rs_data), .read_b_data(rt_data), .v0(register_v0)
    );

    mips_pc i_mips_pc (
        .clk(clk), .rst(rst), .exec1(exec1), .op(op), .imm(imm), .jump_index(jump_index),
        .rs_data(rs_data), .equal(equal), .pc(pc), .pc_link(pc_link), .pc_halt(pc_halt)
    );

    mips_mem_unit i_mips_mem_unit (
        .fetch(fetch), .exec2(exec2), .op(op), .pc(pc), .alu_result(alu_result),
        .store_data(rt_data), .readdata(readdata), .waitrequest(waitrequest),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .load_data(load_data), .mem_stall(mem_stall)
    );

endmodule

// File: tb/mips_iss.svh
`ifndef MIPS_ISS_SVH
`define MIPS_ISS_SVH

// store into the reference image and queue the expected bus write
function automatic void store_ref(logic [31:0] addr, logic [31:0] data, logic [3:0] be);
    ref_mem[word_index(addr)] = merge_bytes(ref_mem[word_index(addr)], data, be);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_be.push_back(be);
endfunction

// instruction-set model with delay slot, returns the final v0
function automatic logic [31:0] iss_run();
    logic [31:0] regs [32];
    logic [31:0] pc, npc, succ, ir, a, b, simm, zimm, ea, ld, res;
    logic [7:0]  lane;
    logic [4:0]  rd;
    logic        wr;
    for (int i = 0; i < 32; i++) regs[i] = 32'h0;
    pc  = reset_vector;
    npc = reset_vector + 32'd4;
    for (int steps = 0; steps < 10000; steps++) begin
        ir   = ref_mem[word_index(pc)];
        a    = regs[ir[25:21]];
        b    = regs[ir[20:16]];
        simm = {{16{ir[15]}}, ir[15:0]};
        zimm = {16'h0, ir[15:0]};
        ea   = a + simm;
        ld   = ref_mem[word_index(ea)];
        lane = ld[8*ea[1:0] +: 8];
        succ = npc + 32'd4;
        res  = 32'h0;
        wr   = 1'b1;
        rd   = (ir[31:26] == 6'h00) ? ir[15:11] : ir[20:16];
        case (ir[31:26])
            6'h00: case (ir[5:0])
                6'h00: res = b << ir[10:6];
                6'h02: res = b >> ir[10:6];
                6'h03: res = $signed(b) >>> ir[10:6];
                6'h08: begin
                    if (a == halt_address) return regs[2];  // delay slot never runs
                    succ = a;
                    wr = 1'b0;
                end
                6'h21: res = a + b;
                6'h23: res = a - b;
                6'h24: res = a & b;
                6'h25: res = a | b;
                6'h26: res = a ^ b;
                6'h2a: res = {31'h0, $signed(a) < $signed(b)};
                6'h2b: res = {31'h0, a < b};
                default: wr = 1'b0;
            endcase
            6'h02: begin
                succ = {npc[31:28], ir[25:0], 2'b00};
                wr = 1'b0;
            end
            6'h03: begin
                succ = {npc[31:28], ir[25:0], 2'b00};
                res = pc + 32'd8;
                rd = 5'd31;
            end
            6'h04: begin
                if (a == b) succ = npc + {simm[29:0], 2'b00};
                wr = 1'b0;
            end
            6'h05: begin
                if (a != b) succ = npc + {simm[29:0], 2'b00};
                wr = 1'b0;
            end
            6'h09: res = a + simm;
            6'h0a: res = {31'h0, $signed(a) < $signed(simm)};
            6'h0b: res = {31'h0, a < simm};
            6'h0c: res = a & zimm;
            6'h0d: res = a | zimm;
            6'h0e: res = a ^ zimm;
            6'h0f: res = {ir[15:0], 16'h0};
            6'h20: res = {{24{lane[7]}}, lane};
            6'h23: res = ld;
            6'h24: res = {24'h0, lane};
            6'h28: begin
                store_ref({ea[31:2], 2'b00}, {4{b[7:0]}}, 4'b0001 << ea[1:0]);
                wr = 1'b0;
            end
            6'h2b: begin
                store_ref({ea[31:2], 2'b00}, b, 4'hf);
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) regs[rd] = res;
        pc  = npc;
        npc = succ;
    end
    return regs[2];                                         // runaway, the halt wait reports it
endfunction

`endif

// File: tb/mips_cpu_tb.sv
`timescale 1ns/1ps

module mips_cpu_tb;
    import mips_pkg::*;

    localparam logic [31:0] data_base = 32'h0000_1000;

    logic        clk, rst, waitrequest, active, read, write;
    logic [31:0] readdata, register_v0, address, writedata;
    logic [3:0]  byteenable;

    logic [31:0] mem [512];         // code words first, then data words
    logic [31:0] ref_mem [512];
    logic [31:0] got_addr[$], got_data[$], exp_addr[$], exp_data[$];
    logic [3:0]  got_be[$], exp_be[$];
    logic [31:0] lfsr_state = 32'hb647_76c5;
    logic [31:0] code_ptr, exp_v0;
    logic        random_wait;
    int          test_errors, tests_ok, tests_bad;

    logic [5:0] alu_functs [7] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h2b};
    logic [5:0] imm_opcodes [7] = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

    mips_cpu_bus i_mips_cpu_bus (
        .clk(clk), .rst(rst), .active(active), .register_v0(register_v0),
        .address(address), .read(read), .write(write), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int word_index(logic [31:0] addr);
        if (addr[31:28] == reset_vector[31:28]) return int'(addr[9:2]);
        return 256 + int'(addr[9:2]);
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data,
                                                logic [3:0] be);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) old[8*b +: 8] = data[8*b +: 8];
        end
        return old;
    endfunction

    `include "mips_iss.svh"

    function automatic logic [31:0] enc_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [4:0] sh, logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(logic [5:0] opc, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(logic [5:0] opc, int k);
        logic [31:0] tgt;
        tgt = reset_vector + 32'(4 * k);                    // k is the instruction slot
        return {opc, tgt[27:2]};
    endfunction

    task automatic put(input logic [31:0] word);
        mem[word_index(code_ptr)] = word;
        code_ptr += 32'd4;
    endtask

    task automatic accumulate(input logic [31:0] word);
        put(word);                                          // result lands in $10
        put(enc_r(2, 10, 2, 0, 6'h21));                     // addu $2, $2, $10
    endtask

    ////////////////////////////////////////////////////////////
    // programs
    ////////////////////////////////////////////////////////////

    task automatic build_program(input int prog);
        logic [31:0] addr;
        for (int i = 0; i < 512; i++) begin
            addr = (i < 256) ? reset_vector + 32'(4 * i) : data_base + 32'(4 * (i - 256));
            mem[i] = {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
        end
        code_ptr = reset_vector;
        put(enc_i(6'h0f, 0, 8, 16'(take_bits(16))));        // lui $8
        put(enc_i(6'h0d, 8, 8, 16'(take_bits(16))));        // ori $8
        case (prog)
            1: begin
                put(enc_i(6'h0f, 0, 9, 16'(take_bits(16))));
                put(enc_i(6'h0d, 9, 9, 16'(take_bits(16))));
                foreach (alu_functs[i]) accumulate(enc_r(8, 9, 10, 0, alu_functs[i]));
                accumulate(enc_r(0, 8, 10, 5'(take_bits(5)), 6'h00));   // sll
                accumulate(enc_r(0, 9, 10, 5'(take_bits(5)), 6'h02));   // srl
                accumulate(enc_r(0, 9, 10, 5'(take_bits(5)), 6'h03));   // sra
                foreach (imm_opcodes[i]) begin
                    accumulate(enc_i(imm_opcodes[i], 9, 10, 16'(take_bits(16))));
                end
            end
            2: begin
                put(enc_i(6'h09, 0, 9, data_base[15:0]));   // base in $9
                put(enc_i(6'h0d, 8, 11, 16'h0080));         // byte with bit 7 set
                put(enc_i(6'h2b, 9, 8, 16'd0));             // sw
                put(enc_i(6'h28, 9, 8, 16'd5));             // sb lane 1
                put(enc_i(6'h28, 9, 11, 16'd10));           // sb lane 2
                put(enc_i(6'h2b, 9, 8, 16'd12));
                accumulate(enc_i(6'h23, 9, 10, 16'd0));     // lw
                accumulate(enc_i(6'h20, 9, 10, 16'd5));     // lb
                accumulate(enc_i(6'h24, 9, 10, 16'd5));     // lbu
                accumulate(enc_i(6'h20, 9, 10, 16'd10));
                accumulate(enc_i(6'h24, 9, 10, 16'd10));
                accumulate(enc_i(6'h20, 9, 10, 16'd15));
                accumulate(enc_i(6'h23, 9, 10, 16'd4));
            end
            default: begin                                  // slots count from zero
                put(enc_r(8, 0, 9, 0, 6'h21));              // 2  $9 = $8
                put(enc_i(6'h09, 0, 10, data_base[15:0]));  // 3
                put(enc_i(6'h04, 8, 9, 16'd2));             // 4  beq taken to 7
                put(enc_i(6'h09, 2, 2, 16'h0001));          // 5  delay slot
                put(enc_i(6'h09, 2, 2, 16'h0100));          // 6  skipped
                put(enc_i(6'h05, 8, 9, 16'd2));             // 7  bne not taken
                put(enc_i(6'h09, 2, 2, 16'h0002));          // 8
                put(enc_i(6'h09, 2, 2, 16'h0200));          // 9
                put(enc_j(6'h03, 15));                      // 10 jal
                put(enc_i(6'h09, 2, 2, 16'h0004));          // 11 delay slot
                put(enc_i(6'h2b, 10, 31, 16'h0020));        // 12 store the link value
                put(enc_j(6'h02, 19));                      // 13 j
                put(enc_r(2, 8, 2, 0, 6'h26));              // 14 delay slot xor
                put(enc_i(6'h09, 2, 2, 16'h0010));          // 15 subroutine
                put(enc_r(31, 0, 0, 0, 6'h08));             // 16 jr $31
                put(enc_i(6'h09, 2, 2, 16'h0020));          // 17 delay slot
                put(enc_i(6'h09, 2, 2, 16'h0400));          // 18 never reached
            end
        endcase
        put(enc_r(0, 0, 0, 0, 6'h08));                      // jr $0 halts
        put(32'h0);
    endtask

    ////////////////////////////////////////////////////////////
    // bus memory model
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        #1;
        waitrequest = random_wait && (take_bits(1) != 32'h0);
        readdata    = mem[word_index(address)];
    end

    always @(negedge clk) begin
        if (!rst && write && !waitrequest) begin           // transfer completes at next edge
            mem[word_index(address)] = merge_bytes(mem[word_index(address)], writedata,
                                                   byteenable);
            got_addr.push_back(address);
            got_data.push_back(writedata);
            got_be.push_back(byteenable);
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_store(input int n, input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] be);
        if (addr !== exp_addr[n]) begin
            $display("** Error: store %0d address got 0x%h expected 0x%h", n, addr, exp_addr[n]);
            test_errors++;
        end
        if (data !== exp_data[n]) begin
            $display("** Error: store %0d writedata got 0x%h expected 0x%h",
                     n, data, exp_data[n]);
            test_errors++;
        end
        if (be !== exp_be[n]) begin
            $display("** Error: store %0d byteenable got 0x%h expected 0x%h", n, be, exp_be[n]);
            test_errors++;
        end
    endtask

    task automatic start_program(input int prog);
        int cycles;
        @(posedge clk);
        #1 rst = 1'b1;
        @(negedge clk);                                     // reload memory while the bus model is idle
        build_program(prog);
        for (int i = 0; i < 512; i++) ref_mem[i] = mem[i];
        got_addr.delete();
        got_data.delete();
        got_be.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_be.delete();
        exp_v0 = iss_run();
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        cycles = 0;
        while (!read && cycles < 4) begin
            @(negedge clk);
            cycles++;
        end
        if (!read) begin
            $display("no fetch read within 4 cycles after reset");
            test_errors++;
        end else begin
            check_word("address", address, reset_vector);
        end
    endtask

    task automatic finish_program();
        int cycles;
        cycles = 0;
        while (active && cycles < 4000) begin
            @(negedge clk);
            cycles++;
        end
        if (active) begin
            $display("active did not fall within 4000 cycles");
            test_errors++;
        end
        check_word("register_v0", register_v0, exp_v0);
        if (got_addr.size() != exp_addr.size()) begin
            $display("the core made %0d stores where %0d were expected",
                     got_addr.size(), exp_addr.size());
            test_errors++;
        end else begin
            foreach (got_addr[i]) check_store(i, got_addr[i], got_data[i], got_be[i]);
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic run_test(input int prog, input logic rand_wait, input string name);
        random_wait = rand_wait;
        start_program(prog);
        finish_program();
        end_test(name);
    endtask

    initial begin
        rst = 1'b1;
        waitrequest = 1'b0;
        readdata = 32'h0;
        random_wait = 1'b0;
        test_errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        run_test(1, 1'b0, "alu and immediate ops");
        run_test(2, 1'b0, "stores and loads");
        run_test(3, 1'b0, "branches and jumps");
        repeat (16) begin                                   // halted core stays quiet
            @(negedge clk);
            check_bit("active", active, 1'b0);
            check_bit("read", read, 1'b0);
            check_bit("write", write, 1'b0);
            check_word("register_v0", register_v0, exp_v0);
        end
        end_test("halt");
        run_test(1, 1'b1, "alu ops, random waitrequest");
        run_test(2, 1'b1, "stores and loads, random waitrequest");
        run_test(3, 1'b1, "branches, random waitrequest");
        random_wait = 1'b1;
        start_program(2);
        repeat (30) @(posedge clk);
        @(negedge clk);
        check_bit("active", active, 1'b1);                  // still running when reset hits
        start_program(2);                                   // reset lands mid-program
        finish_program();
        end_test("reset mid-program");
        $display("%0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0) $display("test passed");
        else $display("test failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+tb
design/mips_pkg.sv
design/mips_sequencer.sv
design/mips_decode.sv
design/mips_alu.sv
design/mips_regfile.sv
design/mips_pc.sv
design/mips_mem_unit.sv
design/mips_cpu_bus.sv
tb/mips_cpu_tb.sv

// File: Bender.yml
package:
  name: mips_cpu_bus

sources:
  - design/mips_pkg.sv
  - design/mips_sequencer.sv
  - design/mips_decode.sv
  - design/mips_alu.sv
  - design/mips_regfile.sv
  - design/mips_pc.sv
  - design/mips_mem_unit.sv
  - design/mips_cpu_bus.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/mips_cpu_tb.sv
